/* logic/axi_mem_defines.svh */
`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// AXI byte address width.
`define AXI_ADDR_WIDTH 16
// AXI data bus width in bits.
`define AXI_DATA_WIDTH 32
// One strobe bit per data byte.
`define AXI_STRB_WIDTH 4
// Transaction ID width.
`define AXI_ID_WIDTH 4
`define AXI_QOS_WIDTH 4
// Burst length field, beats minus one.
`define AXI_LEN_WIDTH 8
`define AXI_SIZE_WIDTH 3

// Byte address into the single memory bank.
`define MEM_ADDR_WIDTH 12
// Requests in flight plus responses not yet sent on R or B.
`define MEM_BUF_DEPTH 2

`endif

/* logic/axi_mem_pkg.sv */
`include "axi_mem_defines.svh"

package axi_mem_pkg;

  // Scalar field types of the AXI channels.
  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_STRB_WIDTH-1:0] strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0]   id_t;
  typedef logic [`AXI_QOS_WIDTH-1:0]  qos_t;
  typedef logic [`AXI_LEN_WIDTH-1:0]  len_t;
  typedef logic [`AXI_SIZE_WIDTH-1:0] size_t;
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [1:0]                 burst_t;
  typedef logic [1:0]                 resp_t;

  // Only incrementing bursts are handled.
  localparam burst_t BURST_INCR  = 2'b01;
  localparam resp_t  RESP_OKAY   = 2'b00;
  localparam resp_t  RESP_SLVERR = 2'b10;

  // AR and AW share one layout.
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    qos_t   qos;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_t resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Everything the bridge needs to know about one beat in flight.
  typedef struct packed {
    mem_addr_t addr;
    id_t       id;
    size_t     size;
    qos_t      qos;
    logic      write;
    logic      last;
  } beat_meta_t;

  typedef struct packed {
    mem_addr_t addr;
    data_t     wdata;
    strb_t     strb;
    logic      we;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

  // Address of the following beat: align to the size, then step by it.
  function automatic mem_addr_t next_beat_addr(mem_addr_t addr, size_t size);
    mem_addr_t step;
    step = mem_addr_t'(1) << size;
    return (addr & ~(step - 1'b1)) + step;
  endfunction

endpackage

/* logic/axi_mem_fifo.sv */
`timescale 1ns/1ps

module axi_mem_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  // Circular pointer step.
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty        = (count_q == '0);
  assign push_ready_o = (count_q != CNT_W'(DEPTH));

  // Empty buffer passes the input straight through.
  assign pop_valid_o = !empty || push_valid_i;
  assign pop_data_o  = empty ? push_data_i : mem_q[rd_ptr_q];

  // A bypassed entry is never stored.
  assign do_push = push_valid_i && push_ready_o && !(empty && pop_ready_i);
  assign do_pop  = pop_ready_i && !empty;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data_i;
  end

  // Producers upstream must respect the credit limit.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_valid_i |-> push_ready_o)
    else $error("FIFO overflow, push while full");

endmodule

/* logic/axi_rd_burst.sv */
`timescale 1ns/1ps

module axi_rd_burst (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ar_valid_i,
  input  axi_mem_pkg::ax_chan_t   ar_i,
  output logic                    ar_ready_o,
  output logic                    beat_valid_o,
  output axi_mem_pkg::beat_meta_t beat_o,
  input  logic                    beat_ready_i,
  output logic                    burst_active_o
);

  import axi_mem_pkg::*;

  // Beats still owed after the one in flight.
  len_t       cnt_q;
  len_t       cnt_d;
  // Template for the next beat, address already advanced.
  beat_meta_t meta_q;

  assign burst_active_o = (cnt_q != '0);

  always_comb begin
    beat_o       = meta_q;
    beat_valid_o = 1'b0;
    ar_ready_o   = 1'b0;
    cnt_d        = cnt_q;
    if (cnt_q != '0) begin
      // Burst under way.
      beat_valid_o = 1'b1;
      beat_o.last  = (cnt_q == len_t'(1));
      if (beat_ready_i) cnt_d = cnt_q - 1'b1;
    end else if (ar_valid_i) begin
      // First beat uses the address as given.
      beat_valid_o = 1'b1;
      beat_o = '{addr: mem_addr_t'(ar_i.addr), id: ar_i.id, size: ar_i.size,
                 qos: ar_i.qos, write: 1'b0, last: (ar_i.len == '0)};
      if (beat_ready_i) begin
        ar_ready_o = 1'b1;
        cnt_d      = ar_i.len;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) cnt_q <= '0;
    else          cnt_q <= cnt_d;
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_o && beat_ready_i) begin
      meta_q      <= beat_o;
      meta_q.addr <= next_beat_addr(beat_o.addr, beat_o.size);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && (ar_i.len != '0) |-> ar_i.burst == BURST_INCR)
    else $error("AR burst type is not INCR");

endmodule

/* logic/axi_wr_burst.sv */
`timescale 1ns/1ps

module axi_wr_burst (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    aw_valid_i,
  input  axi_mem_pkg::ax_chan_t   aw_i,
  output logic                    aw_ready_o,
  input  logic                    w_valid_i,
  input  axi_mem_pkg::w_chan_t    w_i,
  output logic                    w_ready_o,
  output logic                    beat_valid_o,
  output axi_mem_pkg::beat_meta_t beat_o,
  output axi_mem_pkg::w_chan_t    wdata_o,
  input  logic                    beat_ready_i,
  output logic                    burst_active_o
);

  import axi_mem_pkg::*;

  len_t       cnt_q;
  len_t       cnt_d;
  beat_meta_t meta_q;

  // Write data rides along with the beat.
  assign wdata_o        = w_i;
  assign burst_active_o = (cnt_q != '0);

  always_comb begin
    beat_o       = meta_q;
    beat_valid_o = 1'b0;
    aw_ready_o   = 1'b0;
    w_ready_o    = 1'b0;
    cnt_d        = cnt_q;
    if (cnt_q != '0) begin
      // Each further beat waits for its W data.
      beat_valid_o = w_valid_i;
      beat_o.last  = (cnt_q == len_t'(1));
      if (w_valid_i && beat_ready_i) begin
        w_ready_o = 1'b1;
        cnt_d     = cnt_q - 1'b1;
      end
    end else if (aw_valid_i && w_valid_i) begin
      // Address and first data go out together.
      beat_valid_o = 1'b1;
      beat_o = '{addr: mem_addr_t'(aw_i.addr), id: aw_i.id, size: aw_i.size,
                 qos: aw_i.qos, write: 1'b1, last: (aw_i.len == '0)};
      if (beat_ready_i) begin
        aw_ready_o = 1'b1;
        w_ready_o  = 1'b1;
        cnt_d      = aw_i.len;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) cnt_q <= '0;
    else          cnt_q <= cnt_d;
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_o && beat_ready_i) begin
      meta_q      <= beat_o;
      meta_q.addr <= next_beat_addr(beat_o.addr, beat_o.size);
    end
  end

  // W last from the master must match the beat count of the AW burst.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) w_ready_o |-> w_i.last == beat_o.last)
    else $error("W last does not match AW length");

endmodule

/* logic/axi_rw_arbiter.sv */
`timescale 1ns/1ps

module axi_rw_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    rd_valid_i,
  input  axi_mem_pkg::beat_meta_t rd_beat_i,
  output logic                    rd_ready_o,
  input  logic                    rd_active_i,
  input  logic                    wr_valid_i,
  input  axi_mem_pkg::beat_meta_t wr_beat_i,
  input  axi_mem_pkg::w_chan_t    wdata_i,
  output logic                    wr_ready_o,
  input  logic                    wr_active_i,
  output logic                    out_valid_o,
  output axi_mem_pkg::beat_meta_t out_beat_o,
  output axi_mem_pkg::w_chan_t    out_wdata_o,
  input  logic                    out_ready_i
);

  // High selects the write side.
  logic sel_wr;
  logic last_wr_q;
  // Choice is frozen while the output waits.
  logic lock_q;

  always_comb begin
    sel_wr = last_wr_q;
    if (!lock_q) begin
      if (wr_valid_i != rd_valid_i) begin
        sel_wr = wr_valid_i;
      end else if (wr_valid_i) begin
        // Both pending, QoS first.
        if (wr_beat_i.qos != rd_beat_i.qos) begin
          sel_wr = (wr_beat_i.qos > rd_beat_i.qos);
        end else if (wr_beat_i.last && !rd_beat_i.last) begin
          // Single write beat jumps ahead of a read burst.
          sel_wr = 1'b1;
        end else if (wr_active_i) begin
          sel_wr = 1'b1;
        end else if (rd_active_i) begin
          sel_wr = 1'b0;
        end else begin
          // Round robin.
          sel_wr = !last_wr_q;
        end
      end
    end
  end

  assign out_valid_o = sel_wr ? wr_valid_i : rd_valid_i;
  assign out_beat_o  = sel_wr ? wr_beat_i : rd_beat_i;
  // Reads carry no strobes to memory.
  assign out_wdata_o = sel_wr ? wdata_i : '0;
  assign wr_ready_o  = sel_wr && out_ready_i;
  assign rd_ready_o  = !sel_wr && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_wr_q <= 1'b0;
      lock_q    <= 1'b0;
    end else begin
      last_wr_q <= sel_wr;
      lock_q    <= out_valid_o && !out_ready_i;
    end
  end

endmodule

/* logic/axi_mem_port.sv */
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_port (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    beat_valid_i,
  input  axi_mem_pkg::beat_meta_t beat_i,
  input  axi_mem_pkg::w_chan_t    wdata_i,
  output logic                    beat_ready_o,
  output logic                    mem_req_valid_o,
  output axi_mem_pkg::mem_req_t   mem_req_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rsp_valid_i,
  input  axi_mem_pkg::mem_rsp_t   mem_rsp_i,
  output logic                    meta_valid_o,
  output axi_mem_pkg::beat_meta_t meta_o,
  output logic                    rsp_valid_o,
  output axi_mem_pkg::mem_rsp_t   rsp_o,
  input  logic                    pop_ready_i
);

  import axi_mem_pkg::*;

  localparam int unsigned OUT_W = $clog2(`MEM_BUF_DEPTH + 1);

  // Metadata entries equal requests in flight plus unsent responses.
  logic             meta_room;
  logic             req_fire;
  logic [OUT_W-1:0] outstanding_q;

  assign mem_req_valid_o = beat_valid_i && meta_room;
  assign beat_ready_o    = mem_gnt_i && meta_room;
  assign req_fire        = mem_req_valid_o && mem_gnt_i;
  assign mem_req_o = '{addr: beat_i.addr, wdata: wdata_i.data, strb: wdata_i.strb,
                       we: beat_i.write};

  // Granted but not yet answered.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) outstanding_q <= '0;
    else          outstanding_q <= outstanding_q + OUT_W'(req_fire) - OUT_W'(mem_rsp_valid_i);
  end

  axi_mem_fifo #(
    .payload_t(beat_meta_t),
    .DEPTH    (`MEM_BUF_DEPTH)
  ) meta_fifo_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_valid_i(req_fire),
    .push_ready_o(meta_room),
    .push_data_i (beat_i),
    .pop_valid_o (meta_valid_o),
    .pop_ready_i (pop_ready_i),
    .pop_data_o  (meta_o)
  );

  // Memory has no ready, credits keep this buffer from filling.
  axi_mem_fifo #(
    .payload_t(mem_rsp_t),
    .DEPTH    (`MEM_BUF_DEPTH)
  ) rsp_fifo_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_valid_i(mem_rsp_valid_i),
    .push_ready_o(),
    .push_data_i (mem_rsp_i),
    .pop_valid_o (rsp_valid_o),
    .pop_ready_i (pop_ready_i),
    .pop_data_o  (rsp_o)
  );

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_valid_i |-> outstanding_q != '0)
    else $error("memory response without outstanding request");

endmodule

/* logic/axi_resp_compose.sv */
`timescale 1ns/1ps

module axi_resp_compose (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    meta_valid_i,
  input  axi_mem_pkg::beat_meta_t meta_i,
  input  logic                    rsp_valid_i,
  input  axi_mem_pkg::mem_rsp_t   rsp_i,
  output logic                    pop_ready_o,
  output logic                    r_valid_o,
  output axi_mem_pkg::r_chan_t    r_o,
  input  logic                    r_ready_i,
  output logic                    b_valid_o,
  output axi_mem_pkg::b_chan_t    b_o,
  input  logic                    b_ready_i
);

  import axi_mem_pkg::*;

  // Response and its metadata are both at the head.
  logic both_valid;
  // Sticky error over the earlier beats of the write burst.
  logic err_q;
  logic err_acc;

  assign both_valid = meta_valid_i && rsp_valid_i;
  assign err_acc    = err_q || rsp_i.err;

  // Reads go to R beat by beat.
  assign r_valid_o = both_valid && !meta_i.write;
  assign r_o = '{data: rsp_i.rdata, id: meta_i.id,
                 resp: rsp_i.err ? RESP_SLVERR : RESP_OKAY, last: meta_i.last};

  // One B per write burst, on its last beat.
  assign b_valid_o = both_valid && meta_i.write && meta_i.last;
  assign b_o       = '{id: meta_i.id, resp: err_acc ? RESP_SLVERR : RESP_OKAY};

  always_comb begin
    pop_ready_o = 1'b0;
    if (both_valid) begin
      if (!meta_i.write)    pop_ready_o = r_ready_i;
      else if (meta_i.last) pop_ready_o = b_ready_i;
      // Middle write beats are absorbed here.
      else                  pop_ready_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (pop_ready_o && meta_i.write) begin
      err_q <= meta_i.last ? 1'b0 : err_acc;
    end
  end

  // Buffers upstream must hold the head while R is stalled.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
    else $error("R changed while stalled");

endmodule

/* logic/axi_to_mem.sv */
`timescale 1ns/1ps

module axi_to_mem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  ar_valid_i,
  input  axi_mem_pkg::ax_chan_t ar_i,
  output logic                  ar_ready_o,
  input  logic                  aw_valid_i,
  input  axi_mem_pkg::ax_chan_t aw_i,
  output logic                  aw_ready_o,
  input  logic                  w_valid_i,
  input  axi_mem_pkg::w_chan_t  w_i,
  output logic                  w_ready_o,
  output logic                  r_valid_o,
  output axi_mem_pkg::r_chan_t  r_o,
  input  logic                  r_ready_i,
  output logic                  b_valid_o,
  output axi_mem_pkg::b_chan_t  b_o,
  input  logic                  b_ready_i,
  output logic                  mem_req_valid_o,
  output axi_mem_pkg::mem_req_t mem_req_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rsp_valid_i,
  input  axi_mem_pkg::mem_rsp_t mem_rsp_i
);

  import axi_mem_pkg::*;

  // Read beats.
  logic       rd_valid;
  logic       rd_ready;
  logic       rd_active;
  beat_meta_t rd_beat;
  // Write beats with their data.
  logic       wr_valid;
  logic       wr_ready;
  logic       wr_active;
  beat_meta_t wr_beat;
  w_chan_t    wr_data;
  // Arbitrated beat toward the memory.
  logic       arb_valid;
  logic       arb_ready;
  beat_meta_t arb_beat;
  w_chan_t    arb_wdata;
  // Buffered heads toward R and B.
  logic       meta_valid;
  logic       rsp_valid;
  logic       pop_ready;
  beat_meta_t meta;
  mem_rsp_t   rsp;

  axi_rd_burst rd_burst_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ar_valid_i    (ar_valid_i),
    .ar_i          (ar_i),
    .ar_ready_o    (ar_ready_o),
    .beat_valid_o  (rd_valid),
    .beat_o        (rd_beat),
    .beat_ready_i  (rd_ready),
    .burst_active_o(rd_active)
  );

  axi_wr_burst wr_burst_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .aw_valid_i    (aw_valid_i),
    .aw_i          (aw_i),
    .aw_ready_o    (aw_ready_o),
    .w_valid_i     (w_valid_i),
    .w_i           (w_i),
    .w_ready_o     (w_ready_o),
    .beat_valid_o  (wr_valid),
    .beat_o        (wr_beat),
    .wdata_o       (wr_data),
    .beat_ready_i  (wr_ready),
    .burst_active_o(wr_active)
  );

  axi_rw_arbiter arbiter_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd_valid_i (rd_valid),
    .rd_beat_i  (rd_beat),
    .rd_ready_o (rd_ready),
    .rd_active_i(rd_active),
    .wr_valid_i (wr_valid),
    .wr_beat_i  (wr_beat),
    .wdata_i    (wr_data),
    .wr_ready_o (wr_ready),
    .wr_active_i(wr_active),
    .out_valid_o(arb_valid),
    .out_beat_o (arb_beat),
    .out_wdata_o(arb_wdata),
    .out_ready_i(arb_ready)
  );

  axi_mem_port mem_port_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .beat_valid_i   (arb_valid),
    .beat_i         (arb_beat),
    .wdata_i        (arb_wdata),
    .beat_ready_o   (arb_ready),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_gnt_i      (mem_gnt_i),
    .mem_rsp_valid_i(mem_rsp_valid_i),
    .mem_rsp_i      (mem_rsp_i),
    .meta_valid_o   (meta_valid),
    .meta_o         (meta),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp),
    .pop_ready_i    (pop_ready)
  );

  axi_resp_compose compose_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .meta_valid_i(meta_valid),
    .meta_i      (meta),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .pop_ready_o (pop_ready),
    .r_valid_o   (r_valid_o),
    .r_o         (r_o),
    .r_ready_i   (r_ready_i),
    .b_valid_o   (b_valid_o),
    .b_o         (b_o),
    .b_ready_i   (b_ready_i)
  );

endmodule

/* sim/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
  parameter logic [31:0] SEED = 32'h965bbe1a
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  axi_mem_pkg::mem_req_t req_i,
  output logic                  gnt_o,
  output logic                  rsp_valid_o,
  output axi_mem_pkg::mem_rsp_t rsp_o
);

  import axi_mem_pkg::*;

  // One byte per memory address.
  logic [7:0] mem [4096];
  integer     seed = SEED;
  integer     rnd;
  int         a;
  mem_addr_t  word;
  logic       gnt_q = 1'b0;
  // Two stages between grant and response.
  logic       pipe_valid_q = 1'b0;
  mem_rsp_t   pipe_q = '0;
  logic       rsp_valid_q = 1'b0;
  mem_rsp_t   rsp_q = '0;

  assign gnt_o       = gnt_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_q        <= 1'b0;
      pipe_valid_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
      // Fill depends on every address bit.
      for (a = 0; a < 4096; a++) begin
        mem[a] <= 8'(a) ^ {4'(a >> 8), 4'(a >> 8)};
      end
    end else begin
      rnd = $random(seed);
      // Grant about three cycles in four.
      gnt_q        <= (rnd[1:0] != 2'b00);
      pipe_valid_q <= req_valid_i && gnt_q;
      rsp_valid_q  <= pipe_valid_q;
      rsp_q        <= pipe_q;
      // Word access, lanes picked by strobe.
      word = req_i.addr & ~mem_addr_t'(3);
      pipe_q.rdata <= {mem[word + 3], mem[word + 2], mem[word + 1], mem[word]};
      // Upper half of the space answers with an error.
      pipe_q.err   <= (req_i.addr >= 12'h800);
      if (req_valid_i && gnt_q && req_i.we && (req_i.addr < 12'h800)) begin
        for (a = 0; a < 4; a++) begin
          if (req_i.strb[a]) mem[word + a] <= req_i.wdata[8*a +: 8];
        end
      end
    end
  end

endmodule

/* sim/tb_axi_to_mem.sv */
`timescale 1ns/1ps

module tb_axi_to_mem;

  import axi_mem_pkg::*;

  localparam int TIMEOUT = 2000;

  // Expected R beat, mask marks the bytes with known contents.
  typedef struct packed {
    r_chan_t r;
    data_t   mask;
  } exp_r_t;

  logic       clk_i;
  logic       rst_n_i;
  logic       ar_valid_i;
  ax_chan_t   ar_i;
  logic       ar_ready_o;
  logic       aw_valid_i;
  ax_chan_t   aw_i;
  logic       aw_ready_o;
  logic       w_valid_i;
  w_chan_t    w_i;
  logic       w_ready_o;
  logic       r_valid_o;
  r_chan_t    r_o;
  logic       r_ready_i = 1'b0;
  logic       b_valid_o;
  b_chan_t    b_o;
  logic       b_ready_i = 1'b0;
  logic       mem_req_valid_o;
  mem_req_t   mem_req_o;
  logic       mem_gnt_i;
  logic       mem_rsp_valid_i;
  mem_rsp_t   mem_rsp_i;

  // Reference image of the bytes written so far.
  logic [7:0] ref_mem [4096];
  bit         ref_known [4096];
  exp_r_t     exp_r_q [$];
  b_chan_t    exp_b_q [$];
  exp_r_t     exp_r;
  b_chan_t    exp_b;
  integer     seed = 32'h965bbe1a;
  integer     rnd;
  logic       bp_en = 1'b0;
  // First granted request after arming must match arb_we.
  logic       arb_armed = 1'b0;
  logic       arb_we = 1'b0;
  logic       arb_done = 1'b0;
  logic       seen_edge = 1'b0;
  logic       after_rst = 1'b0;
  logic       r_hold = 1'b0;
  logic       b_hold = 1'b0;
  r_chan_t    r_prev;
  b_chan_t    b_prev;

  axi_to_mem axi_to_mem_i (.*);

  tb_mem_model mem_model_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(mem_req_valid_o),
    .req_i      (mem_req_o),
    .gnt_o      (mem_gnt_i),
    .rsp_valid_o(mem_rsp_valid_i),
    .rsp_o      (mem_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_test(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else abort_test($sformatf("error at %0t ns: %s expected 0x%0h got 0x%0h",
                                $time, name, exp, got));
  endtask

  // INCR rule, first beat as given, then aligned start plus i steps.
  function automatic int beat_addr(input int start, input int size, input int i);
    int step;
    step = 1 << size;
    return (i == 0) ? start : (start & ~(step - 1)) + i * step;
  endfunction

  function automatic data_t beat_data(input data_t base, input int i);
    return base ^ (data_t'(i) * 32'h0101_0101);
  endfunction

  task automatic predict_write(input int id, input int start, input int len,
                               input strb_t strb, input data_t base);
    data_t   d;
    b_chan_t eb;
    int      a;
    int      w;
    logic    err;
    err = 1'b0;
    for (int i = 0; i <= len; i++) begin
      a = beat_addr(start, 2, i);
      d = beat_data(base, i);
      if (a >= 'h800) begin
        err = 1'b1;
      end else begin
        for (int b = 0; b < 4; b++) begin
          w = (a & ~3) + b;
          if (strb[b]) begin
            ref_mem[w]   = d[8*b +: 8];
            ref_known[w] = 1'b1;
          end
        end
      end
    end
    // One B per burst, any failing beat makes it SLVERR.
    eb.id   = id_t'(id);
    eb.resp = err ? RESP_SLVERR : RESP_OKAY;
    exp_b_q.push_back(eb);
  endtask

  task automatic predict_read(input int id, input int start, input int len);
    exp_r_t e;
    int     a;
    int     w;
    for (int i = 0; i <= len; i++) begin
      a        = beat_addr(start, 2, i);
      e        = '0;
      e.r.id   = id_t'(id);
      e.r.last = (i == len);
      e.r.resp = (a >= 'h800) ? RESP_SLVERR : RESP_OKAY;
      // Error beats carry no data worth checking.
      if (a < 'h800) begin
        for (int b = 0; b < 4; b++) begin
          w = (a & ~3) + b;
          if (ref_known[w]) begin
            e.r.data[8*b +: 8] = ref_mem[w];
            e.mask[8*b +: 8]   = 8'hff;
          end
        end
      end
      exp_r_q.push_back(e);
    end
  endtask

  task automatic drive_ar(input int id, input int start, input int len, input int qos);
    int cycles;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_i <= '{id: id_t'(id), addr: addr_t'(start), len: len_t'(len), size: 3'd2,
              burst: BURST_INCR, qos: qos_t'(qos)};
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) abort_test("timeout waiting for the AR handshake");
    end while (!ar_ready_o);
    ar_valid_i <= 1'b0;
  endtask

  task automatic drive_write(input int id, input int start, input int len, input int qos,
                             input strb_t strb, input data_t base);
    int cycles;
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_i <= '{id: id_t'(id), addr: addr_t'(start), len: len_t'(len), size: 3'd2,
              burst: BURST_INCR, qos: qos_t'(qos)};
    for (int i = 0; i <= len; i++) begin
      w_valid_i <= 1'b1;
      w_i       <= '{data: beat_data(base, i), strb: strb, last: (i == len)};
      cycles = 0;
      do begin
        @(posedge clk_i);
        cycles++;
        if (cycles > TIMEOUT) abort_test("timeout waiting for a W handshake");
      end while (!w_ready_o);
      // AW goes with the first beat.
      aw_valid_i <= 1'b0;
    end
    w_valid_i <= 1'b0;
  endtask

  task automatic write_burst(input int id, input int start, input int len,
                             input strb_t strb, input data_t base);
    predict_write(id, start, len, strb, base);
    drive_write(id, start, len, 0, strb, base);
  endtask

  task automatic read_burst(input int id, input int start, input int len);
    predict_read(id, start, len);
    drive_ar(id, start, len, 0);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) abort_test("timeout waiting for outstanding R and B responses");
    end
  endtask

  // Read and write hit an idle bridge in the same cycle.
  task automatic race_read_write(input int wr_qos, input int rd_qos);
    arb_we    <= (wr_qos > rd_qos);
    arb_armed <= 1'b1;
    predict_write(9, 'h400, 1, 4'hf, 32'h600d_beef);
    predict_read(10, 'h100, 3);
    fork
      drive_write(9, 'h400, 1, wr_qos, 4'hf, 32'h600d_beef);
      drive_ar(10, 'h100, 3, rd_qos);
    join
    wait_drain();
    arb_armed <= 1'b0;
    @(posedge clk_i);
  endtask

  // R and B readiness, random once enabled.
  always @(posedge clk_i) begin
    rnd = $random(seed);
    r_ready_i <= bp_en ? rnd[0] : 1'b1;
    b_ready_i <= bp_en ? rnd[1] : 1'b1;
  end

  always @(posedge clk_i) begin
    // Handshake outputs quiet during and just after reset.
    if ((!rst_n_i && seen_edge) || after_rst) begin
      check_value("{ar_ready_o,aw_ready_o,w_ready_o,r_valid_o,b_valid_o,mem_req_valid_o}",
                  {ar_ready_o, aw_ready_o, w_ready_o, r_valid_o, b_valid_o,
                   mem_req_valid_o}, '0);
    end
    if (rst_n_i) begin
      // Stalled payloads must hold.
      if (r_hold) begin
        check_value("r_valid_o", r_valid_o, 1'b1);
        check_value("r_o", r_o, r_prev);
      end
      if (b_hold) begin
        check_value("b_valid_o", b_valid_o, 1'b1);
        check_value("b_o", b_o, b_prev);
      end
      if (r_valid_o && r_ready_i) begin
        if (exp_r_q.size() == 0) begin
          abort_test("R beat arrived with no read beat outstanding");
        end else begin
          exp_r = exp_r_q.pop_front();
          check_value("r_o.id", r_o.id, exp_r.r.id);
          check_value("r_o.resp", r_o.resp, exp_r.r.resp);
          check_value("r_o.last", r_o.last, exp_r.r.last);
          check_value("r_o.data", r_o.data & exp_r.mask, exp_r.r.data);
        end
      end
      if (b_valid_o && b_ready_i) begin
        if (exp_b_q.size() == 0) begin
          abort_test("B response arrived with no write burst outstanding");
        end else begin
          exp_b = exp_b_q.pop_front();
          check_value("b_o.id", b_o.id, exp_b.id);
          check_value("b_o.resp", b_o.resp, exp_b.resp);
        end
      end
      if (arb_armed && !arb_done && mem_req_valid_o && mem_gnt_i) begin
        check_value("mem_req_o.we", mem_req_o.we, arb_we);
      end
    end
    seen_edge <= 1'b1;
    after_rst <= !rst_n_i;
    r_hold    <= rst_n_i && r_valid_o && !r_ready_i;
    b_hold    <= rst_n_i && b_valid_o && !b_ready_i;
    r_prev    <= r_o;
    b_prev    <= b_o;
    arb_done  <= arb_armed && (arb_done || (mem_req_valid_o && mem_gnt_i));
  end

  initial begin
    rst_n_i    = 1'b0;
    ar_valid_i = 1'b0;
    ar_i       = '0;
    aw_valid_i = 1'b0;
    aw_i       = '0;
    w_valid_i  = 1'b0;
    w_i        = '0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Single beat readback with a partial strobe.
    write_burst(1, 'h040, 0, 4'b0101, 32'hcafe_f00d);
    wait_drain();
    read_burst(2, 'h040, 0);
    wait_drain();
    // Everything below runs with R and B stalling at random.
    bp_en <= 1'b1;
    write_burst(3, 'h100, 7, 4'hf, 32'h1234_5678);
    wait_drain();
    read_burst(4, 'h100, 7);
    // Unaligned start.
    read_burst(5, 'h10a, 3);
    wait_drain();
    // Bursts across the error boundary.
    write_burst(6, 'h7f8, 3, 4'hf, 32'h0bad_0bad);
    wait_drain();
    read_burst(7, 'h7f8, 3);
    wait_drain();
    // Round robin would pick the other side in each of these races.
    race_read_write(1, 12);
    race_read_write(9, 2);
    repeat (4) @(posedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* src.f */
+incdir+logic
logic/axi_mem_pkg.sv
logic/axi_mem_fifo.sv
logic/axi_rd_burst.sv
logic/axi_wr_burst.sv
logic/axi_rw_arbiter.sv
logic/axi_mem_port.sv
logic/axi_resp_compose.sv
logic/axi_to_mem.sv
sim/tb_mem_model.sv
sim/tb_axi_to_mem.sv

/* Bender.yml */
package:
  name: axi_to_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/axi_mem_pkg.sv
      - logic/axi_mem_fifo.sv
      - logic/axi_rd_burst.sv
      - logic/axi_wr_burst.sv
      - logic/axi_rw_arbiter.sv
      - logic/axi_mem_port.sv
      - logic/axi_resp_compose.sv
      - logic/axi_to_mem.sv
  - target: test
    files:
      - sim/tb_mem_model.sv
      - sim/tb_axi_to_mem.sv
